/* verilog.f */
rtl/ctrl_pkg.sv
rtl/ctrl_if.sv
rtl/alu_decode.sv
rtl/flow_decode.sv
rtl/writeback_decode.sv
rtl/hazard_check.sv
rtl/control.sv
test/control_asserts.sv
test/control_tb.sv

/* run.sh */
#!/bin/sh
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module control_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcontrol_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

exit 0

/* test/control_tb.sv */
`timescale 1ns/1ps

module control_tb import ctrl_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int RAND_COUNT  = 2000;
    localparam int NOP_CYCLES  = 20;
    // reset, halt pair, sweep, random, nop toggle, unlisted opcodes
    localparam int TEST_CYCLES = 3 + 2 + 256 + RAND_COUNT + NOP_CYCLES + 8;

    typedef struct packed {
        alu_op_t      alu_op;
        alu_b_sel_t   alu_b_sel;
        logic         inv_b;
        logic         swap;
        logic         cin;
        logic         sign;
        logic         halt;
        logic         br;
        br_type_t     br_type;
        logic         jump;
        logic         jal;
        logic         rs;
        logic         pc_a_sel;
        logic         pc_b_sel;
        logic         reg_write_en;
        wb_data_sel_t data_sel;
        wb_reg_sel_t  reg_sel;
        logic         mem_read;
        logic         mem_write;
        logic         check_rs;
        logic         check_rt;
    } ctrl_word_t;

    logic         clk = 1'b0;
    instr_t       instr;
    logic         rst_n;
    logic         stall;
    alu_op_t      alu_op;
    alu_b_sel_t   alu_b_sel;
    logic         inv_b;
    logic         swap;
    logic         cin;
    logic         sign;
    logic         halt;
    logic         br;
    br_type_t     br_type;
    logic         jump;
    logic         jal;
    logic         rs;
    logic         pc_a_sel;
    logic         pc_b_sel;
    logic         reg_write_en;
    wb_data_sel_t reg_write_data_sel;
    wb_reg_sel_t  reg_write_reg_sel;
    logic         mem_read;
    logic         mem_write;
    logic         check_rs;
    logic         check_rt;
    ctrl_word_t   exp_word;

    control u_dut (.*);

    bind control control_asserts u_asserts (
        .clk               (control_tb.clk),
        .br                (br),
        .jump              (jump),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .jal               (jal),
        .reg_write_en      (reg_write_en),
        .reg_write_reg_sel (reg_write_reg_sel),
        .halt              (halt),
        .rst_n             (rst_n)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic ctrl_word_t expected_ctrl(instr_t ins, logic rst_in, logic stall_in);
        ctrl_word_t e;
        opcode_t    op;
        func_t      fn;
        logic       imm_alu;  // alu and shift immediates
        logic       reg_alu;  // r-type groups and compares
        logic       sub_fn;
        e       = '0;
        op      = ins[15:11];
        fn      = ins[1:0];
        imm_alu = op inside {OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
                             OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI};
        reg_alu = op inside {OP_RTYPE_ARITH, OP_RTYPE_SHIFT, OP_SEQ, OP_SLT, OP_SLE, OP_SCO};
        sub_fn  = (op == OP_RTYPE_ARITH) && (fn == FN_SUB);
        case (op)
            OP_ADDI, OP_SUBI, OP_ST, OP_LD, OP_STU, OP_JALR: e.alu_op = ALU_ADD;
            OP_XORI:  e.alu_op = ALU_XOR;
            OP_ANDNI: e.alu_op = ALU_AND;
            OP_SLLI:  e.alu_op = ALU_SLL;
            OP_RORI:  e.alu_op = ALU_ROR;
            OP_SRLI:  e.alu_op = ALU_SRL;
            OP_SEQ:   e.alu_op = ALU_SEQ;
            OP_SLT:   e.alu_op = ALU_SLT;
            OP_SLE:   e.alu_op = ALU_SLE;
            OP_SCO:   e.alu_op = ALU_SCO;
            OP_BTR:   e.alu_op = ALU_BTR;
            OP_LBI:   e.alu_op = ALU_LBI;
            OP_SLBI:  e.alu_op = ALU_SLBI;
            OP_RTYPE_ARITH: e.alu_op = (fn == FN_ADD) ? ALU_ADD : (fn == FN_SUB) ? ALU_SUB
                                     : (fn == FN_XOR) ? ALU_XOR : ALU_AND;
            OP_RTYPE_SHIFT: e.alu_op = (fn == FN_SLL) ? ALU_SLL : (fn == FN_SRL) ? ALU_SRL
                                     : (fn == FN_ROL) ? ALU_ROL : ALU_ROR;
            default:  e.alu_op = ALU_ROL;  // roli and the rest are code 0
        endcase
        if (op inside {OP_ADDI, OP_SUBI, OP_ST, OP_LD, OP_STU})
            e.alu_b_sel = ALU_B_SE5;
        else if (imm_alu)
            e.alu_b_sel = ALU_B_ZE5;
        else if (reg_alu)
            e.alu_b_sel = ALU_B_REG;
        else if (op inside {OP_LBI, OP_SLBI, OP_JR, OP_JALR})
            e.alu_b_sel = ALU_B_SE8;
        e.inv_b  = (op inside {OP_SUBI, OP_ANDNI}) || sub_fn
                || ((op == OP_RTYPE_ARITH) && (fn == FN_ANDN));
        e.swap   = (op == OP_SUBI) || sub_fn;
        e.cin    = (op inside {OP_SUBI, OP_SLT, OP_SLE}) || sub_fn;
        e.sign   = op inside {OP_ST, OP_LD, OP_STU, OP_SEQ, OP_SLT, OP_SCO};
        e.halt   = (op == OP_HALT) && rst_in;
        e.br     = op inside {OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ};
        e.br_type = e.br ? br_type_t'(op[1:0]) : BR_EQZ;  // low opcode bits
        e.jump   = op inside {OP_J, OP_JR, OP_JAL, OP_JALR};
        e.jal    = op inside {OP_JAL, OP_JALR};
        e.rs     = (op == OP_JALR);
        e.pc_a_sel = !(op inside {OP_HALT, OP_NOP, OP_JR, 5'b00010, 5'b00011});
        e.pc_b_sel = op inside {OP_J, OP_JAL};
        e.reg_write_en = imm_alu || reg_alu
                      || (op inside {OP_LD, OP_STU, OP_LBI, OP_SLBI, OP_BTR, OP_JAL, OP_JALR});
        if (e.jal)
            e.reg_sel = WB_R7;
        else if (imm_alu || op inside {OP_ST, OP_LD})
            e.reg_sel = WB_RD_7_5;
        else if (reg_alu || op == OP_BTR)
            e.reg_sel = WB_RD_4_2;
        if (e.jal)
            e.data_sel = WB_PC_INC;
        else if (imm_alu || reg_alu || op inside {OP_NOP, OP_STU, OP_LBI, OP_SLBI, OP_BTR})
            e.data_sel = WB_ALU;
        e.mem_read  = op inside {OP_ST, OP_LD, OP_STU};
        e.mem_write = op inside {OP_ST, OP_STU};
        if (op == OP_ST || reg_alu) begin
            e.check_rs = 1'b1;
            e.check_rt = 1'b1;
        end else if (imm_alu || e.br || op inside {OP_LD, OP_STU, OP_BTR, OP_SLBI}) begin
            e.check_rs = 1'b1;
        end else if (op == OP_NOP) begin
            e.check_rs = stall_in;
            e.check_rt = stall_in;
        end
        return e;
    endfunction

    task automatic abort_run(string why);
        $display("Errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run("decoded output mismatch");
        end
    endtask

    task automatic check_alu_op(alu_op_t got, alu_op_t exp);
        if (got !== exp) begin
            $display("FAIL alu_op got %h expected %h", got, exp);
            abort_run("decoded output mismatch");
        end
    endtask

    task automatic check_alu_b_sel(alu_b_sel_t got, alu_b_sel_t exp);
        if (got !== exp) begin
            $display("FAIL alu_b_sel got %h expected %h", got, exp);
            abort_run("decoded output mismatch");
        end
    endtask

    task automatic check_wb_data_sel(wb_data_sel_t got, wb_data_sel_t exp);
        if (got !== exp) begin
            $display("FAIL reg_write_data_sel got %h expected %h", got, exp);
            abort_run("decoded output mismatch");
        end
    endtask

    task automatic check_wb_reg_sel(wb_reg_sel_t got, wb_reg_sel_t exp);
        if (got !== exp) begin
            $display("FAIL reg_write_reg_sel got %h expected %h", got, exp);
            abort_run("decoded output mismatch");
        end
    endtask

    task automatic check_br_type(br_type_t got, br_type_t exp);
        if (got !== exp) begin
            $display("FAIL br_type got %h expected %h", got, exp);
            abort_run("decoded output mismatch");
        end
    endtask

    task automatic apply(instr_t ins, logic st);
        @(posedge clk);
        #1;
        instr = ins;
        stall = st;
    endtask

    // inputs settle 1 ns after the rising edge, so the falling edge sees stable outputs
    always @(negedge clk) begin
        exp_word = expected_ctrl(instr, rst_n, stall);
        check_alu_op(alu_op, exp_word.alu_op);
        check_alu_b_sel(alu_b_sel, exp_word.alu_b_sel);
        check_bit("inv_b", inv_b, exp_word.inv_b);
        check_bit("swap", swap, exp_word.swap);
        check_bit("cin", cin, exp_word.cin);
        check_bit("sign", sign, exp_word.sign);
        check_bit("halt", halt, exp_word.halt);
        check_bit("br", br, exp_word.br);
        check_br_type(br_type, exp_word.br_type);
        check_bit("jump", jump, exp_word.jump);
        check_bit("jal", jal, exp_word.jal);
        check_bit("rs", rs, exp_word.rs);
        check_bit("pc_a_sel", pc_a_sel, exp_word.pc_a_sel);
        check_bit("pc_b_sel", pc_b_sel, exp_word.pc_b_sel);
        check_bit("reg_write_en", reg_write_en, exp_word.reg_write_en);
        check_wb_data_sel(reg_write_data_sel, exp_word.data_sel);
        check_wb_reg_sel(reg_write_reg_sel, exp_word.reg_sel);
        check_bit("mem_read", mem_read, exp_word.mem_read);
        check_bit("mem_write", mem_write, exp_word.mem_write);
        check_bit("check_rs", check_rs, exp_word.check_rs);
        check_bit("check_rt", check_rt, exp_word.check_rt);
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Errors found");
        $fatal(1, "timeout, the test sequence did not finish in time");
    end

    initial begin
        void'($urandom(32'h8e777aeb));
        instr = {OP_NOP, 11'd0};
        stall = 1'b0;
        rst_n = 1'b0;
        apply({OP_HALT, 11'h155}, 1'b0);  // halt masked while in reset
        @(negedge clk);
        check_bit("halt", halt, 1'b0);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        apply({OP_HALT, 11'h155}, 1'b0);
        @(negedge clk);
        check_bit("halt", halt, 1'b1);
        for (int op = 0; op < 32; op++) begin
            for (int fn = 0; fn < 4; fn++) begin
                for (int st = 0; st < 2; st++) begin
                    apply({opcode_t'(op), 9'($urandom), func_t'(fn)}, 1'(st));
                end
            end
        end
        for (int i = 0; i < RAND_COUNT; i++) begin
            apply(instr_t'($urandom), 1'($urandom));
        end
        for (int i = 0; i < NOP_CYCLES; i++) begin
            apply({OP_NOP, 11'($urandom)}, 1'(i));  // stall toggles
            @(negedge clk);
            check_bit("check_rs", check_rs, 1'(i));
            check_bit("check_rt", check_rt, 1'(i));
            check_bit("mem_write", mem_write, 1'b0);
            check_bit("reg_write_en", reg_write_en, 1'b0);
        end
        for (int op = 2; op < 4; op++) begin  // former siic and rti
            for (int n = 0; n < 4; n++) begin
                apply({opcode_t'(op), 11'($urandom)}, 1'($urandom));
                @(negedge clk);
                check_bit("pc_a_sel", pc_a_sel, 1'b0);
                check_bit("mem_write", mem_write, 1'b0);
                check_bit("reg_write_en", reg_write_en, 1'b0);
                check_alu_op(alu_op, alu_op_t'(0));
            end
        end
        @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

/* test/control_asserts.sv */
`timescale 1ns/1ps

module control_asserts import ctrl_pkg::*; (
    input logic        clk,
    input logic        br,
    input logic        jump,
    input logic        mem_read,
    input logic        mem_write,
    input logic        jal,
    input logic        reg_write_en,
    input wb_reg_sel_t reg_write_reg_sel,
    input logic        halt,
    input logic        rst_n
);

    // one pc redirect source per word
    br_jump_excl: assert property (@(posedge clk) !(br && jump))
        else $error("br and jump are high together");

    store_reads: assert property (@(posedge clk) mem_write |-> mem_read)
        else $error("mem_write without mem_read");

    link_to_r7: assert property (@(posedge clk)
        jal |-> (reg_write_en && reg_write_reg_sel == WB_R7))
        else $error("jal without a write to r7");

    halt_out_of_reset: assert property (@(posedge clk) halt |-> rst_n)
        else $error("halt raised during reset");

endmodule

/* rtl/control.sv */
`timescale 1ns/1ps

module control import ctrl_pkg::*; (
    input  instr_t       instr,
    input  logic         rst_n,
    input  logic         stall,
    output alu_op_t      alu_op,
    output alu_b_sel_t   alu_b_sel,
    output logic         inv_b,
    output logic         swap,
    output logic         cin,
    output logic         sign,
    output logic         halt,
    output logic         br,
    output br_type_t     br_type,
    output logic         jump,
    output logic         jal,
    output logic         rs,
    output logic         pc_a_sel,
    output logic         pc_b_sel,
    output logic         reg_write_en,
    output wb_data_sel_t reg_write_data_sel,
    output wb_reg_sel_t  reg_write_reg_sel,
    output logic         mem_read,
    output logic         mem_write,
    output logic         check_rs,
    output logic         check_rt
);

    alu_ctrl_if  alu_bus ();
    flow_ctrl_if flow_bus ();

    alu_decode u_alu_decode (
        .instr (instr),
        .alu   (alu_bus.src)
    );

    flow_decode u_flow_decode (
        .instr (instr),
        .rst_n (rst_n),
        .flow  (flow_bus.src)
    );

    writeback_decode u_writeback_decode (
        .instr              (instr),
        .reg_write_en       (reg_write_en),
        .reg_write_data_sel (reg_write_data_sel),
        .reg_write_reg_sel  (reg_write_reg_sel),
        .mem_read           (mem_read),
        .mem_write          (mem_write)
    );

    hazard_check u_hazard_check (
        .instr    (instr),
        .stall    (stall),
        .check_rs (check_rs),
        .check_rt (check_rt)
    );

    // execute stage controls
    assign alu_op    = alu_bus.alu_op;
    assign alu_b_sel = alu_bus.alu_b_sel;
    assign inv_b     = alu_bus.inv_b;
    assign swap      = alu_bus.swap;
    assign cin       = alu_bus.cin;
    assign sign      = alu_bus.sign;

    // fetch and pc controls
    assign halt     = flow_bus.halt;
    assign br       = flow_bus.br;
    assign br_type  = flow_bus.br_type;
    assign jump     = flow_bus.jump;
    assign jal      = flow_bus.jal;
    assign rs       = flow_bus.rs;
    assign pc_a_sel = flow_bus.pc_a_sel;
    assign pc_b_sel = flow_bus.pc_b_sel;

endmodule

/* rtl/hazard_check.sv */
`timescale 1ns/1ps

module hazard_check import ctrl_pkg::*; (
    input  instr_t instr,
    input  logic   stall,
    output logic   check_rs,
    output logic   check_rt
);

    opcode_t opcode;

    assign opcode = instr[15:11];

    always_comb begin
        check_rs = 1'b0;
        check_rt = 1'b0;
        case (opcode)
            OP_ST, OP_RTYPE_ARITH, OP_RTYPE_SHIFT,
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                check_rs = 1'b1;
                check_rt = 1'b1;    // both sources read
            end
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI,
            OP_LD, OP_STU, OP_BTR, OP_SLBI,
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: check_rs = 1'b1;
            OP_NOP: begin
                check_rs = stall;   // bubble keeps the compare alive
                check_rt = stall;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/writeback_decode.sv */
`timescale 1ns/1ps

module writeback_decode import ctrl_pkg::*; (
    input  instr_t       instr,
    output logic         reg_write_en,
    output wb_data_sel_t reg_write_data_sel,
    output wb_reg_sel_t  reg_write_reg_sel,
    output logic         mem_read,
    output logic         mem_write
);

    opcode_t opcode;
    logic    is_alu_imm;  // i-format alu and shift immediates
    logic    is_alu_reg;  // r-type groups and compares

    assign opcode = instr[15:11];

    assign is_alu_imm = (opcode inside {OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
                                        OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI});
    assign is_alu_reg = (opcode inside {OP_RTYPE_ARITH, OP_RTYPE_SHIFT,
                                        OP_SEQ, OP_SLT, OP_SLE, OP_SCO});

    assign reg_write_en = is_alu_imm || is_alu_reg
                       || (opcode inside {OP_LD, OP_STU, OP_LBI, OP_SLBI, OP_BTR,
                                          OP_JAL, OP_JALR});

    // st also raises the read strobe
    assign mem_read  = (opcode inside {OP_ST, OP_LD, OP_STU});
    assign mem_write = (opcode inside {OP_ST, OP_STU});

    always_comb begin
        if (is_alu_imm || opcode == OP_ST || opcode == OP_LD) begin
            reg_write_reg_sel = WB_RD_7_5;
        end else if (is_alu_reg || opcode == OP_BTR) begin
            reg_write_reg_sel = WB_RD_4_2;
        end else if (opcode == OP_JAL || opcode == OP_JALR) begin
            reg_write_reg_sel = WB_R7;      // link register
        end else begin
            reg_write_reg_sel = WB_RD_10_8; // stu, lbi, slbi
        end
    end

    always_comb begin
        if (opcode == OP_JAL || opcode == OP_JALR) begin
            reg_write_data_sel = WB_PC_INC;
        end else if (is_alu_imm || is_alu_reg
                     || (opcode inside {OP_NOP, OP_STU, OP_LBI, OP_SLBI, OP_BTR})) begin
            reg_write_data_sel = WB_ALU;
        end else begin
            reg_write_data_sel = WB_MEM;
        end
    end

endmodule

/* rtl/flow_decode.sv */
`timescale 1ns/1ps

module flow_decode import ctrl_pkg::*; (
    input  instr_t      instr,
    input  logic        rst_n,
    flow_ctrl_if.src    flow
);

    opcode_t opcode;

    assign opcode = instr[15:11];

    // halt is held off while the core is in reset
    assign flow.halt = (opcode == OP_HALT) && rst_n;

    assign flow.jump = (opcode inside {OP_J, OP_JR, OP_JAL, OP_JALR});
    assign flow.jal  = (opcode inside {OP_JAL, OP_JALR});
    assign flow.rs   = (opcode == OP_JALR);

    assign flow.pc_b_sel = (opcode inside {OP_J, OP_JAL});  // 11-bit displacement

    always_comb begin
        flow.br      = 1'b1;
        flow.br_type = BR_EQZ;
        case (opcode)
            OP_BEQZ: flow.br_type = BR_EQZ;
            OP_BNEZ: flow.br_type = BR_NEZ;
            OP_BLTZ: flow.br_type = BR_LTZ;
            OP_BGEZ: flow.br_type = BR_GEZ;
            default: flow.br = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_HALT, OP_NOP, OP_JR: flow.pc_a_sel = 1'b0;
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
            OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI,
            OP_ST, OP_LD, OP_STU, OP_BTR,
            OP_RTYPE_ARITH, OP_RTYPE_SHIFT,
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO,
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ,
            OP_LBI, OP_SLBI, OP_J, OP_JAL, OP_JALR:
                flow.pc_a_sel = 1'b1;   // pc_inc feeds the adder
            default: flow.pc_a_sel = 1'b0;  // former siic / rti slots
        endcase
    end

endmodule

/* rtl/alu_decode.sv */
`timescale 1ns/1ps

module alu_decode import ctrl_pkg::*; (
    input  instr_t         instr,
    alu_ctrl_if.src        alu
);

    opcode_t opcode;
    func_t   func;

    assign opcode = instr[15:11];
    assign func   = instr[1:0];

    always_comb begin
        alu.alu_op    = ALU_ROL;    // 0 when unused
        alu.alu_b_sel = ALU_B_ZERO;
        alu.inv_b     = 1'b0;
        alu.swap      = 1'b0;
        alu.cin       = 1'b0;
        alu.sign      = 1'b0;
        case (opcode)
            OP_ADDI: begin
                alu.alu_op    = ALU_ADD;
                alu.alu_b_sel = ALU_B_SE5;
            end
            OP_SUBI: begin
                alu.alu_op    = ALU_ADD;
                alu.alu_b_sel = ALU_B_SE5;
                alu.inv_b     = 1'b1;  // imm - rs
                alu.swap      = 1'b1;
                alu.cin       = 1'b1;
            end
            OP_ST, OP_LD, OP_STU: begin
                alu.alu_op    = ALU_ADD;    // address calc
                alu.alu_b_sel = ALU_B_SE5;
                alu.sign      = 1'b1;
            end
            OP_XORI: begin
                alu.alu_op    = ALU_XOR;
                alu.alu_b_sel = ALU_B_ZE5;
            end
            OP_ANDNI: begin
                alu.alu_op    = ALU_AND;
                alu.alu_b_sel = ALU_B_ZE5;
                alu.inv_b     = 1'b1;
            end
            OP_ROLI: begin
                alu.alu_op    = ALU_ROL;
                alu.alu_b_sel = ALU_B_ZE5;
            end
            OP_SLLI: begin
                alu.alu_op    = ALU_SLL;
                alu.alu_b_sel = ALU_B_ZE5;
            end
            OP_RORI: begin
                alu.alu_op    = ALU_ROR;
                alu.alu_b_sel = ALU_B_ZE5;
            end
            OP_SRLI: begin
                alu.alu_op    = ALU_SRL;
                alu.alu_b_sel = ALU_B_ZE5;
            end
            OP_RTYPE_ARITH: begin
                alu.alu_b_sel = ALU_B_REG;
                case (func)
                    FN_ADD:  alu.alu_op = ALU_ADD;
                    FN_SUB: begin
                        alu.alu_op = ALU_SUB;
                        alu.inv_b  = 1'b1;
                        alu.swap   = 1'b1;  // rt - rs
                        alu.cin    = 1'b1;
                    end
                    FN_XOR:  alu.alu_op = ALU_XOR;
                    FN_ANDN: begin
                        alu.alu_op = ALU_AND;
                        alu.inv_b  = 1'b1;
                    end
                endcase
            end
            OP_RTYPE_SHIFT: begin
                alu.alu_b_sel = ALU_B_REG;  // shift amount from rt
                case (func)
                    FN_SLL: alu.alu_op = ALU_SLL;
                    FN_SRL: alu.alu_op = ALU_SRL;
                    FN_ROL: alu.alu_op = ALU_ROL;
                    FN_ROR: alu.alu_op = ALU_ROR;
                endcase
            end
            OP_SEQ: begin
                alu.alu_op    = ALU_SEQ;
                alu.alu_b_sel = ALU_B_REG;
                alu.sign      = 1'b1;
            end
            OP_SLT: begin
                alu.alu_op    = ALU_SLT;
                alu.alu_b_sel = ALU_B_REG;
                alu.cin       = 1'b1;
                alu.sign      = 1'b1;
            end
            OP_SLE: begin
                alu.alu_op    = ALU_SLE;
                alu.alu_b_sel = ALU_B_REG;
                alu.cin       = 1'b1;
            end
            OP_SCO: begin
                alu.alu_op    = ALU_SCO;
                alu.alu_b_sel = ALU_B_REG;
                alu.sign      = 1'b1;
            end
            OP_BTR: alu.alu_op = ALU_BTR;   // b unused
            OP_LBI: begin
                alu.alu_op    = ALU_LBI;
                alu.alu_b_sel = ALU_B_SE8;
            end
            OP_SLBI: begin
                alu.alu_op    = ALU_SLBI;
                alu.alu_b_sel = ALU_B_SE8;
            end
            OP_JR:   alu.alu_b_sel = ALU_B_SE8;  // rs + imm8 target
            OP_JALR: begin
                alu.alu_op    = ALU_ADD;
                alu.alu_b_sel = ALU_B_SE8;
            end
            default: ;
        endcase
    end

endmodule

/* rtl/ctrl_if.sv */
`timescale 1ns/1ps

interface alu_ctrl_if import ctrl_pkg::*; ();
    alu_op_t    alu_op;
    alu_b_sel_t alu_b_sel;
    logic       inv_b;  // complement operand b
    logic       swap;   // exchange a and b
    logic       cin;
    logic       sign;   // signed compare / overflow

    modport src (output alu_op, alu_b_sel, inv_b, swap, cin, sign);
    modport dst (input alu_op, alu_b_sel, inv_b, swap, cin, sign);
endinterface

interface flow_ctrl_if import ctrl_pkg::*; ();
    logic     halt;
    logic     br;
    br_type_t br_type;
    logic     jump;
    logic     jal;       // link into r7
    logic     rs;        // target from register
    logic     pc_a_sel;  // 1 = pc_inc
    logic     pc_b_sel;  // 1 = 11-bit disp, 0 = 8-bit

    modport src (
        output halt, br, br_type, jump, jal, rs, pc_a_sel, pc_b_sel
    );
    modport dst (
        input halt, br, br_type, jump, jal, rs, pc_a_sel, pc_b_sel
    );
endinterface

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

    typedef logic [15:0] instr_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [1:0]  func_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  alu_b_sel_t;
    typedef logic [1:0]  wb_data_sel_t;
    typedef logic [1:0]  wb_reg_sel_t;
    typedef logic [1:0]  br_type_t;

    // major opcodes in instr[15:11]
    localparam opcode_t OP_HALT        = 5'b00000;
    localparam opcode_t OP_NOP         = 5'b00001;
    localparam opcode_t OP_J           = 5'b00100;
    localparam opcode_t OP_JR          = 5'b00101;
    localparam opcode_t OP_JAL         = 5'b00110;
    localparam opcode_t OP_JALR        = 5'b00111;
    localparam opcode_t OP_ADDI        = 5'b01000;
    localparam opcode_t OP_SUBI        = 5'b01001;
    localparam opcode_t OP_XORI        = 5'b01010;
    localparam opcode_t OP_ANDNI       = 5'b01011;
    localparam opcode_t OP_BEQZ        = 5'b01100;
    localparam opcode_t OP_BNEZ        = 5'b01101;
    localparam opcode_t OP_BLTZ        = 5'b01110;
    localparam opcode_t OP_BGEZ        = 5'b01111;
    localparam opcode_t OP_ST          = 5'b10000;
    localparam opcode_t OP_LD          = 5'b10001;
    localparam opcode_t OP_SLBI        = 5'b10010;
    localparam opcode_t OP_STU         = 5'b10011;
    localparam opcode_t OP_ROLI        = 5'b10100;
    localparam opcode_t OP_SLLI        = 5'b10101;
    localparam opcode_t OP_RORI        = 5'b10110;
    localparam opcode_t OP_SRLI        = 5'b10111;
    localparam opcode_t OP_LBI         = 5'b11000;
    localparam opcode_t OP_BTR         = 5'b11001;
    localparam opcode_t OP_RTYPE_SHIFT = 5'b11010;
    localparam opcode_t OP_RTYPE_ARITH = 5'b11011;
    localparam opcode_t OP_SEQ         = 5'b11100;
    localparam opcode_t OP_SLT         = 5'b11101;
    localparam opcode_t OP_SLE         = 5'b11110;
    localparam opcode_t OP_SCO         = 5'b11111;

    // function field in instr[1:0]
    localparam func_t FN_ADD  = 2'b00;
    localparam func_t FN_SUB  = 2'b01;
    localparam func_t FN_XOR  = 2'b10;
    localparam func_t FN_ANDN = 2'b11;
    localparam func_t FN_SLL  = 2'b00;
    localparam func_t FN_SRL  = 2'b01;
    localparam func_t FN_ROL  = 2'b10;
    localparam func_t FN_ROR  = 2'b11;

    localparam alu_op_t ALU_ROL  = 4'd0;
    localparam alu_op_t ALU_SLL  = 4'd1;
    localparam alu_op_t ALU_ROR  = 4'd2;
    localparam alu_op_t ALU_SRL  = 4'd3;
    localparam alu_op_t ALU_ADD  = 4'd4;
    localparam alu_op_t ALU_AND  = 4'd5;
    localparam alu_op_t ALU_XOR  = 4'd7;
    localparam alu_op_t ALU_SCO  = 4'd8;
    localparam alu_op_t ALU_SLBI = 4'd9;
    localparam alu_op_t ALU_BTR  = 4'd10;
    localparam alu_op_t ALU_SLT  = 4'd11;
    localparam alu_op_t ALU_LBI  = 4'd12;
    localparam alu_op_t ALU_SLE  = 4'd13;
    localparam alu_op_t ALU_SEQ  = 4'd14;
    localparam alu_op_t ALU_SUB  = 4'd15;

    localparam alu_b_sel_t ALU_B_ZERO = 3'd0;
    localparam alu_b_sel_t ALU_B_REG  = 3'd1;
    localparam alu_b_sel_t ALU_B_SE8  = 3'd2;
    localparam alu_b_sel_t ALU_B_SE5  = 3'd3;
    localparam alu_b_sel_t ALU_B_ZE5  = 3'd4;

    localparam wb_data_sel_t WB_MEM    = 2'd0;
    localparam wb_data_sel_t WB_ALU    = 2'd1;
    localparam wb_data_sel_t WB_PC_INC = 2'd3;

    localparam wb_reg_sel_t WB_RD_10_8 = 2'd0;
    localparam wb_reg_sel_t WB_RD_7_5  = 2'd1;
    localparam wb_reg_sel_t WB_RD_4_2  = 2'd2;
    localparam wb_reg_sel_t WB_R7      = 2'd3;

    localparam br_type_t BR_EQZ = 2'd0;
    localparam br_type_t BR_NEZ = 2'd1;
    localparam br_type_t BR_LTZ = 2'd2;
    localparam br_type_t BR_GEZ = 2'd3;

endpackage
